//--- run.sh
#!/bin/sh
# Build and run the classifier testbench with Verilator.
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f src.f --top-module nnClassifierTb -o simv

# The simulator status is not trusted alone, the log decides.
./obj_dir/simv > sim.log 2>&1 || true
cat sim.log

if grep -q "tests failed" sim.log; then
	echo "simulation reported failure" >&2
	exit 1
fi
if ! grep -q "all tests passed" sim.log; then
	echo "simulation ended without a result" >&2
	exit 1
fi
exit 0

//--- src.f
+incdir+verilog
verilog/nnTypesPkg.sv
verilog/wbBusPkg.sv
verilog/wbSlaveRegs.sv
verilog/neuronNode.sv
verilog/classifierSelect.sv
verilog/nnClassifierTop.sv
verif/nnClassifier_props.sv
verif/nnClassifierTb.sv

//--- verif/nnClassifierTb.sv
`timescale 1ns/1ps
`default_nettype none
`include "nn_defines.svh"

module nnClassifierTb;

	localparam int cycleLimit = 20000; // About 30 polled passes plus margin.

	logic clk;
	logic reset;
	wbBusPkg::wbReqT wbReq;
	wbBusPkg::wbRespT wbResp;
	logic signed [7:0] actVals [`NN_INPUTS];
	int errorCount;
	int checkCount;
	int cycleCount;

	nnClassifierTop dut_i (.clk(clk), .reset(reset), .wbReq(wbReq), .wbResp(wbResp));

	always #10 clk = ~clk;

	always @(posedge clk)
	begin
		cycleCount <= cycleCount + 1;
		if (cycleCount >= cycleLimit)
		begin
			$display("timeout after %0d cycles", cycleCount);
			$display("tests failed");
			$finish;
		end
	end

	task automatic checkValue(input string name, input logic [31:0] expected,
		input logic [31:0] actual);
		checkCount++;
		assert (actual == expected)
		else
		begin
			errorCount++;
			$display("mismatch at %0t: %s expected 0x%08h actual 0x%08h", $time, name,
				expected, actual);
		end
	endtask

	// ==============================
	// Bus tasks
	// ==============================
	task automatic busAccess(input logic write, input logic [`WB_ADR_W-1:0] addr,
		input logic [31:0] wdata, output logic [31:0] rdata);
		int waits;
		waits = 0;
		rdata = '0;
		wbReq = '{cyc: 1'b1, stb: 1'b1, we: write, adr: addr, dat: wdata};
		@(negedge clk);
		while (!wbResp.ack && waits < 16)
		begin
			@(negedge clk);
			waits++;
		end
		if (wbResp.ack)
			rdata = wbResp.dat;
		else
		begin
			errorCount++;
			$display("no ack from the DUT for address %0d", addr);
		end
		wbReq = '0; // Drop stb once ack is seen.
		@(negedge clk);
	endtask

	task automatic busWrite(input logic [`WB_ADR_W-1:0] addr, input logic [31:0] data);
		logic [31:0] ignored;
		busAccess(1'b1, addr, data, ignored);
	endtask

	task automatic busRead(input logic [`WB_ADR_W-1:0] addr, output logic [31:0] data);
		busAccess(1'b0, addr, '0, data);
	endtask

	task automatic loadVector();
		for (int i = 0; i < `NN_INPUTS; i++)
			busWrite(6'(i), {24'd0, actVals[i]});
	endtask

	task automatic waitDone();
		logic [31:0] status;
		int polls;
		polls = 0;
		busRead(`NN_REG_STATUS, status);
		while (!status[1] && polls < 40)
		begin
			busRead(`NN_REG_STATUS, status);
			polls++;
		end
		if (!status[1])
		begin
			errorCount++;
			$display("status never showed done after a start");
		end
	endtask

	// ==============================
	// Reference model
	// ==============================
	function automatic int signOf(input int x);
		if (x > 0)
			return 1;
		if (x < 0)
			return -1;
		return 0;
	endfunction

	function automatic logic [15:0] nodeReference(input int node);
		int sum;
		logic [15:0] wrapped;
		sum = int'(nnTypesPkg::nodeBias[node]);
		for (int i = 0; i < `NN_INPUTS; i++)
			sum += int'(actVals[i]) * int'(nnTypesPkg::nodeWeights[node][i]);
		wrapped = 16'(sum); // Wraps like the hardware sum.
		return wrapped[15] ? 16'd0 : wrapped;
	endfunction

	task automatic checkResults();
		logic [15:0] exp0;
		logic [15:0] exp1;
		logic [31:0] expResult;
		logic [31:0] readValue;
		exp0 = nodeReference(0);
		exp1 = nodeReference(1);
		expResult = (exp1 > exp0) ? {15'd0, 1'b1, exp1} : {15'd0, 1'b0, exp0};
		busRead(`NN_REG_NODE0, readValue);
		checkValue("NODE0", {16'd0, exp0}, readValue);
		busRead(`NN_REG_NODE1, readValue);
		checkValue("NODE1", {16'd0, exp1}, readValue);
		busRead(`NN_REG_RESULT, readValue);
		checkValue("RESULT", expResult, readValue);
	endtask

	initial
	begin
		logic [31:0] readValue;
		logic signed [7:0] newValue;
		int slot;
		void'($urandom(8));
		clk = 1'b0;
		reset = 1'b1;
		wbReq = '0;
		errorCount = 0;
		checkCount = 0;
		cycleCount = 0;
		repeat (16) @(negedge clk);
		reset = 1'b0;

		// Idle register values.
		busRead(`NN_REG_STATUS, readValue);
		checkValue("STATUS", 32'd0, readValue);
		busRead(`NN_REG_RESULT, readValue);
		checkValue("RESULT", 32'd0, readValue);
		busRead(6'd40, readValue);
		checkValue("unmapped", 32'd0, readValue);

		// Zero vector leaves only the biases.
		foreach (actVals[i])
			actVals[i] = '0;
		loadVector();
		busWrite(`NN_REG_CTRL, 32'd1);
		waitDone();
		checkResults();

		// Node 0 driven positive, then negative.
		foreach (actVals[i])
			actVals[i] = 8'(4 * signOf(int'(nnTypesPkg::nodeWeights[0][i])));
		loadVector();
		busWrite(`NN_REG_CTRL, 32'd1);
		waitDone();
		checkResults();
		foreach (actVals[i])
			actVals[i] = -actVals[i];
		loadVector();
		busWrite(`NN_REG_CTRL, 32'd1);
		waitDone();
		checkResults();

		// Node 1 wins, then a tie at zero.
		foreach (actVals[i])
			actVals[i] = 8'(2 * signOf(int'(nnTypesPkg::nodeWeights[1][i]))
				- 2 * signOf(int'(nnTypesPkg::nodeWeights[0][i])));
		loadVector();
		busWrite(`NN_REG_CTRL, 32'd1);
		waitDone();
		checkResults();
		foreach (actVals[i])
			actVals[i] = 8'(-2 * signOf(int'(nnTypesPkg::nodeWeights[1][i]))
				- 2 * signOf(int'(nnTypesPkg::nodeWeights[0][i])));
		loadVector();
		busWrite(`NN_REG_CTRL, 32'd1);
		waitDone();
		busRead(`NN_REG_RESULT, readValue);
		checkValue("RESULT", 32'd0, readValue);
		checkResults();

		// ==============================
		// Random vectors
		// ==============================
		for (int pass = 0; pass < 20; pass++)
		begin
			foreach (actVals[i])
				actVals[i] = 8'($urandom);
			loadVector();
			busWrite(`NN_REG_CTRL, 32'd1);
			if (pass % 4 == 1)
			begin
				newValue = 8'($urandom);
				busWrite(6'd0, {24'd0, newValue}); // Slot changed mid-pass.
				busWrite(`NN_REG_CTRL, 32'd1);
				waitDone();
				repeat (8) @(negedge clk);
				checkResults();
			end
			else
			begin
				waitDone();
				checkResults();
			end
		end

		// Busy, then done, then one slot rewritten.
		foreach (actVals[i])
			actVals[i] = 8'($urandom);
		loadVector();
		busWrite(`NN_REG_CTRL, 32'd1);
		busRead(`NN_REG_STATUS, readValue);
		checkValue("STATUS", 32'd1, readValue);
		waitDone();
		busRead(`NN_REG_STATUS, readValue);
		checkValue("STATUS", 32'd2, readValue);
		checkResults();
		slot = int'($urandom_range(`NN_INPUTS - 1));
		actVals[slot] = 8'($urandom);
		busWrite(6'(slot), {24'd0, actVals[slot]});
		busWrite(`NN_REG_CTRL, 32'd1);
		waitDone();
		checkResults();

		$display("%0d checks, %0d errors", checkCount, errorCount);
		if (errorCount == 0)
			$display("all tests passed");
		else
			$display("tests failed");
		$finish;
	end

endmodule

`default_nettype wire

//--- verif/nnClassifier_props.sv
`timescale 1ns/1ps
`default_nettype none
`include "nn_defines.svh"

module nnClassifierProps (
	input logic clk,
	input logic reset,
	input wbBusPkg::wbReqT wbReq,
	input wbBusPkg::wbRespT wbResp,
	input logic start,
	input nnTypesPkg::nodeResultT node0Result,
	input nnTypesPkg::nodeResultT node1Result
);

	// ==============================
	// Bus handshake
	// ==============================
	ackNeedsRequest: assert property (@(posedge clk) disable iff (reset)
		$rose(wbResp.ack) |-> $past(wbReq.cyc && wbReq.stb))
		else $error("ack rose without cyc and stb");

	ackSingleCycle: assert property (@(posedge clk) disable iff (reset)
		wbResp.ack |=> !wbResp.ack)
		else $error("ack high for two cycles");

	// Node valid lags start by three stages.
	node0Latency: assert property (@(posedge clk) disable iff (reset)
		node0Result.valid == $past(start, 3))
		else $error("node 0 valid out of step with start");

	node1Latency: assert property (@(posedge clk) disable iff (reset)
		node1Result.valid == $past(start, 3))
		else $error("node 1 valid out of step with start");

	node0Positive: assert property (@(posedge clk) disable iff (reset)
		node0Result.valid |-> !node0Result.value[`NN_ACC_W-1])
		else $error("node 0 output is negative");

	node1Positive: assert property (@(posedge clk) disable iff (reset)
		node1Result.valid |-> !node1Result.value[`NN_ACC_W-1])
		else $error("node 1 output is negative");

endmodule

bind nnClassifierTop nnClassifierProps props_i (
	.clk(clk),
	.reset(reset),
	.wbReq(wbReq),
	.wbResp(wbResp),
	.start(start),
	.node0Result(node0Result),
	.node1Result(node1Result)
);

`default_nettype wire

//--- verilog/classifierSelect.sv
`timescale 1ns/1ps
`default_nettype none

module classifierSelect (
	input logic clk,
	input logic reset,
	input nnTypesPkg::nodeResultT node0,
	input nnTypesPkg::nodeResultT node1,
	output nnTypesPkg::classResultT classResult
);

	logic bothValid;

	assign bothValid = node0.valid & node1.valid;

	always_ff @(posedge clk)
	begin
		if (reset)
			classResult <= '0;
		else
		begin
			classResult.valid <= bothValid;
			if (bothValid)
			begin
				// A tie goes to class 0.
				if (node1.value > node0.value)
				begin
					classResult.classIdx <= 1'b1;
					classResult.value <= node1.value;
				end
				else
				begin
					classResult.classIdx <= 1'b0;
					classResult.value <= node0.value;
				end
			end
		end
	end

endmodule

`default_nettype wire

//--- verilog/neuronNode.sv
`timescale 1ns/1ps
`default_nettype none
`include "nn_defines.svh"

module neuronNode #(
	parameter int nodeIndex = 0
) (
	input logic clk,
	input logic reset,
	input nnTypesPkg::activationVecT activations,
	input logic start,
	output nnTypesPkg::nodeResultT result
);

	nnTypesPkg::activationVecT actReg;
	logic actValid;
	nnTypesPkg::accumT sumNext;
	nnTypesPkg::accumT sumReg;
	logic sumValid;

	// Valid bits walk beside the data.
	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			actValid <= 1'b0;
			sumValid <= 1'b0;
		end
		else
		begin
			actValid <= start;
			sumValid <= actValid;
		end
	end

	always_ff @(posedge clk)
	begin
		if (start)
			actReg <= activations;
		if (actValid)
			sumReg <= sumNext;
	end

	// Bias plus products, wrapping at the accumulator width.
	always_comb
	begin
		nnTypesPkg::accumT acc;
		nnTypesPkg::accumT term;
		acc = nnTypesPkg::accumT'(nnTypesPkg::nodeBias[nodeIndex]);
		for (int i = 0; i < `NN_INPUTS; i++)
		begin
			term = nnTypesPkg::accumT'($signed(actReg[i]))
				* nnTypesPkg::accumT'(nnTypesPkg::nodeWeights[nodeIndex][i]);
			acc = acc + term;
		end
		sumNext = acc;
	end

	// Rectifier on the full sign bit.
	always_ff @(posedge clk)
	begin
		if (reset)
			result <= '0;
		else
		begin
			result.valid <= sumValid;
			if (sumValid)
				result.value <= sumReg[`NN_ACC_W-1] ? '0 : sumReg;
		end
	end

endmodule

`default_nettype wire

//--- verilog/nnClassifierTop.sv
`timescale 1ns/1ps
`default_nettype none

module nnClassifierTop (
	input logic clk,
	input logic reset,
	input wbBusPkg::wbReqT wbReq,
	output wbBusPkg::wbRespT wbResp
);

	nnTypesPkg::activationVecT activations;
	logic start;
	nnTypesPkg::nodeResultT node0Result;
	nnTypesPkg::nodeResultT node1Result;
	nnTypesPkg::classResultT classResult;

	wbSlaveRegs regs_i (
		.clk(clk),
		.reset(reset),
		.wbReq(wbReq),
		.wbResp(wbResp),
		.activations(activations),
		.start(start),
		.classResult(classResult),
		.node0(node0Result),
		.node1(node1Result)
	);

	// ==============================
	// Two nodes on one vector
	// ==============================
	neuronNode #(.nodeIndex(0)) node0_i (
		.clk(clk),
		.reset(reset),
		.activations(activations),
		.start(start),
		.result(node0Result)
	);

	neuronNode #(.nodeIndex(1)) node1_i (
		.clk(clk),
		.reset(reset),
		.activations(activations),
		.start(start),
		.result(node1Result)
	);

	classifierSelect select_i (
		.clk(clk),
		.reset(reset),
		.node0(node0Result),
		.node1(node1Result),
		.classResult(classResult)
	);

endmodule

`default_nettype wire

//--- verilog/nnTypesPkg.sv
`default_nettype none
`include "nn_defines.svh"

package nnTypesPkg;

	typedef logic signed [`NN_ACT_W-1:0] activationT;
	typedef logic signed [`NN_ACT_W-1:0] weightT;
	typedef logic signed [`NN_ACC_W-1:0] accumT;

	typedef activationT [`NN_INPUTS-1:0] activationVecT; // Slot 0 in the low byte.

	typedef struct packed {
		logic valid;
		accumT value;
	} nodeResultT;

	typedef struct packed {
		logic valid;
		logic classIdx;
		accumT value;
	} classResultT;

	// ==============================
	// Fixed weights, one row per node.
	// ==============================
	localparam weightT nodeWeights [2][`NN_INPUTS] = '{
		'{ -4,   28,  66, -49,   5,  65,  28, -122,  24, -96,
		  -22,   24,  40,   5,  60, -60,  62,   27,  -6,   2,
		  -18,   63, -58, -30, -17,  30,  39,   -1,  18,   6 },
		'{ 17,  -35,   9,  44, -12,   3, -57,   21,  38,  -8,
		   50,  -27,  14,  -3, -41,  26,   7,  -19,  33,  61,
		   -5,  -46,  11,  29, -24,   2,  48,  -31,  15,  -9 }
	};

	localparam weightT nodeBias [2] = '{ -7, 12 };

endpackage

`default_nettype wire

//--- verilog/nn_defines.svh
`ifndef NN_DEFINES_SVH
`define NN_DEFINES_SVH

// Network shape and data widths.
`define NN_INPUTS 30
`define NN_ACT_W 8
`define NN_ACC_W 16

// Wishbone word address width.
`define WB_ADR_W 6

// ==============================
// Register map, word addresses.
// ==============================
// Addresses 0 to 29 are the activation slots.
`define NN_REG_CTRL 6'd32
`define NN_REG_STATUS 6'd33
`define NN_REG_RESULT 6'd34
`define NN_REG_NODE0 6'd35
`define NN_REG_NODE1 6'd36

`endif

//--- verilog/wbBusPkg.sv
`default_nettype none
`include "nn_defines.svh"

package wbBusPkg;

	// Master to slave, Wishbone classic.
	typedef struct packed {
		logic cyc;
		logic stb;
		logic we;
		logic [`WB_ADR_W-1:0] adr;
		logic [31:0] dat;
	} wbReqT;

	// Slave to master.
	typedef struct packed {
		logic ack;
		logic [31:0] dat;
	} wbRespT;

endpackage

`default_nettype wire

//--- verilog/wbSlaveRegs.sv
`timescale 1ns/1ps
`default_nettype none
`include "nn_defines.svh"

module wbSlaveRegs (
	input logic clk,
	input logic reset,
	input wbBusPkg::wbReqT wbReq,
	output wbBusPkg::wbRespT wbResp,
	output nnTypesPkg::activationVecT activations,
	output logic start,
	input nnTypesPkg::classResultT classResult,
	input nnTypesPkg::nodeResultT node0,
	input nnTypesPkg::nodeResultT node1
);

	typedef enum logic [1:0] {stateIdle, stateBusy, stateDone} stateT;

	stateT state;
	nnTypesPkg::activationVecT actBuf;
	logic ack;
	logic access;
	logic ctrlWrite;
	logic [31:0] readMux;
	logic [31:0] readData;
	logic resultClass;
	nnTypesPkg::accumT resultValue;
	nnTypesPkg::accumT node0Val;
	nnTypesPkg::accumT node1Val;

	assign access = wbReq.cyc & wbReq.stb & ~ack; // Ack lasts one clock.
	assign ctrlWrite = access & wbReq.we & (wbReq.adr == `NN_REG_CTRL) & wbReq.dat[0];

	// ==============================
	// Bus handshake
	// ==============================
	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			ack <= 1'b0;
			readData <= '0;
		end
		else
		begin
			ack <= access;
			if (access & ~wbReq.we)
				readData <= readMux;
		end
	end

	always_comb
	begin
		case (wbReq.adr)
			`NN_REG_STATUS: readMux = {30'd0, state == stateDone, state == stateBusy};
			`NN_REG_RESULT: readMux = {15'd0, resultClass, resultValue};
			`NN_REG_NODE0: readMux = {16'd0, node0Val};
			`NN_REG_NODE1: readMux = {16'd0, node1Val};
			default: readMux = '0;
		endcase
	end

	assign wbResp.ack = ack;
	assign wbResp.dat = readData;

	// Activation buffer, kept between passes.
	always_ff @(posedge clk)
	begin
		if (reset)
			actBuf <= '0;
		else if (access & wbReq.we & (wbReq.adr < `NN_INPUTS))
			actBuf[wbReq.adr[4:0]] <= nnTypesPkg::activationT'(wbReq.dat[`NN_ACT_W-1:0]);
	end

	assign activations = actBuf;

	// ==============================
	// Pass control
	// ==============================
	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			state <= stateIdle;
			start <= 1'b0;
		end
		else
		begin
			start <= 1'b0;
			case (state)
				stateBusy:
				begin
					if (classResult.valid)
						state <= stateDone;
				end
				default:
				begin
					if (ctrlWrite)
					begin
						state <= stateBusy;
						start <= 1'b1; // Same clock as the ack.
					end
				end
			endcase
		end
	end

	// Results held for readback.
	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			resultClass <= 1'b0;
			resultValue <= '0;
			node0Val <= '0;
			node1Val <= '0;
		end
		else
		begin
			if (classResult.valid)
			begin
				resultClass <= classResult.classIdx;
				resultValue <= classResult.value;
			end
			if (node0.valid)
				node0Val <= node0.value;
			if (node1.valid)
				node1Val <= node1.value;
		end
	end

endmodule

`default_nettype wire
